//--- Bender.yml
package:
  name: acq_top

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/acq_pkg.sv
      - rtl/acq_sequencer.sv
      - rtl/adc_capture.sv
      - rtl/sample_fifo.sv
      - rtl/sample_readout.sv
      - rtl/acq_top.sv

  - target: simulation
    files:
      - bench/adc_model.sv
      - bench/tb_acq_top.sv

//--- bench/adc_model.sv
// behavioral adc model

`timescale 1ns/1ps

`include "acq_defines.svh"

module adc_model
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         measure_trig,
  output logic                         measure_valid,
  output logic [`ACQ_SAMPLE_WIDTH-1:0] result
);

  // conversion time in clk cycles
  localparam int MIN_DELAY   = 3;
  localparam int MAX_DELAY   = 40;
  // valid stays up long enough for the two flop synchronizer
  localparam int HOLD_CYCLES = 5;

  int unsigned delay;

  initial
  begin
    measure_valid = 1'b0;
    result        = '0;
    forever
    begin
      // trigger is a one cycle pulse, look at it mid cycle
      @(negedge clk);
      if (!reset && measure_trig)
      begin
        delay = MIN_DELAY + ($urandom % (MAX_DELAY - MIN_DELAY + 1));
        repeat (delay) @(posedge clk);
        #2;
        // new code shows up together with valid
        result        = `ACQ_SAMPLE_WIDTH'($urandom);
        measure_valid = 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        #2;
        // result is held until the next conversion
        measure_valid = 1'b0;
      end
    end
  end

endmodule

//--- bench/tb_acq_top.sv
// acquisition testbench

`timescale 1ns/1ps

`include "acq_defines.svh"

module tb_acq_top
  import acq_pkg::*;
;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 8;
  localparam int PRE            = `ACQ_PRECHARGE_CYCLES;
  localparam int DEPTH          = `ACQ_FIFO_DEPTH;
  localparam int SAMPLE_TIMEOUT = 4 * (PRE + 60);
  localparam int HOLD_WINDOW    = (DEPTH + 3) * (PRE + 60);
  // 400 samples at worst case cycle length, plus margin
  localparam int WATCHDOG_NS    = 400 * (PRE + 45) * CLK_PERIOD + 20000;

  logic                         clk;
  logic                         reset;
  logic                         arm_trigger;
  logic                         rd_ack;
  logic                         rd_valid;
  sample_t                      rd_sample;
  logic                         spi_irq_n;
  logic                         adc_measure_trig;
  logic                         adc_measure_valid;
  logic [`ACQ_SAMPLE_WIDTH-1:0] adc_result;
  logic                         led0;
  logic [1:0]                   monitor;

  // reference model state
  logic [`ACQ_SAMPLE_WIDTH-1:0] exp_q[$];
  logic [7:0] exp_seq = 8'd0;
  int trig_count      = 0;
  int ack_count       = 0;
  int irq_count       = 0;
  int irq_stray       = 0;
  int cycle           = 0;
  int last_trig_cycle = 0;
  int min_gap         = 1000000;
  int max_outstanding = 0;
  int led_toggles     = 0;
  int led_checked     = 0;
  int led_bad         = 0;
  bit led_check_en    = 1'b1;
  logic valid_prev;
  logic led_prev;
  // valid edges on their way to the capture push
  logic [2:0] push_pipe;
  logic       exp_push;

  // bookkeeping
  string cur_test;
  int errors          = 0;
  int errors_at_start = 0;
  int tests_passed    = 0;
  int tests_failed    = 0;

  acq_top u_acq_top (
    .clk               (clk),
    .reset             (reset),
    .arm_trigger       (arm_trigger),
    .rd_valid          (rd_valid),
    .rd_sample         (rd_sample),
    .spi_irq_n         (spi_irq_n),
    .rd_ack            (rd_ack),
    .adc_measure_trig  (adc_measure_trig),
    .adc_measure_valid (adc_measure_valid),
    .adc_result        (adc_result),
    .led0              (led0),
    .monitor           (monitor)
  );

  adc_model u_adc_model (
    .clk           (clk),
    .reset         (reset),
    .measure_trig  (adc_measure_trig),
    .measure_valid (adc_measure_valid),
    .result        (adc_result)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reporting

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR in %s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    int test_errors;
    test_errors = errors - errors_at_start;
    if (test_errors == 0)
    begin
      tests_passed++;
      $display("test %s: ok", cur_test);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d check(s) failed", cur_test, test_errors);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitors, sampled mid cycle

  always @(negedge clk)
  begin
    if (reset)
    begin
      valid_prev = 1'b0;
      led_prev   = 1'b0;
      push_pipe  = 3'b000;
    end
    else
    begin
      cycle++;

      // capture push shows on the scope pin three cycles after valid rises
      exp_push  = push_pipe[2];
      push_pipe = {push_pipe[1:0], adc_measure_valid & ~valid_prev};
      if (monitor[1] !== exp_push)
        report_mismatch("monitor[1] capture push", exp_push, monitor[1]);
      if (monitor[0] !== adc_measure_trig)
        report_mismatch("monitor[0] trigger", adc_measure_trig, monitor[0]);

      // every adc answer is the next value the host should see
      if (adc_measure_valid && !valid_prev)
        exp_q.push_back(adc_result);
      valid_prev = adc_measure_valid;

      if (led0 !== led_prev)
        led_toggles++;
      led_prev = led0;

      if (adc_measure_trig)
      begin
        trig_count++;
        if (trig_count > 1 && (cycle - last_trig_cycle) < min_gap)
          min_gap = cycle - last_trig_cycle;
        last_trig_cycle = cycle;
        // one blink per cycle while no arm edge disturbs the loop
        if (led_check_en)
        begin
          led_checked++;
          if (led_toggles != 1)
            led_bad++;
        end
        led_toggles = 0;
        if (trig_count - ack_count > max_outstanding)
          max_outstanding = trig_count - ack_count;
      end

      if (!spi_irq_n)
      begin
        irq_count++;
        if (!rd_valid)
          irq_stray++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // host model

  task automatic check_idle_outputs();
    if (adc_measure_trig !== 1'b0)
      report_mismatch("adc_measure_trig", 1'b0, adc_measure_trig);
    if (rd_valid !== 1'b0)
      report_mismatch("rd_valid", 1'b0, rd_valid);
    if (led0 !== 1'b0)
      report_mismatch("led0", 1'b0, led0);
    if (spi_irq_n !== 1'b1)
      report_mismatch("spi_irq_n", 1'b1, spi_irq_n);
    if (monitor !== 2'b00)
      report_mismatch("monitor", 2'b00, monitor);
  endtask

  // wait for a held sample, compare it, then ack after a gap
  task automatic receive_sample(input int unsigned ack_gap);
    int      waited;
    sample_t got;
    logic [`ACQ_SAMPLE_WIDTH-1:0] exp_value;
    waited = 0;
    @(negedge clk);
    while (!rd_valid && waited < SAMPLE_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!rd_valid)
      report_problem($sformatf("no sample reached the host in %0d cycles", SAMPLE_TIMEOUT));
    else
    begin
      got = rd_sample;
      if (exp_q.size() == 0)
        report_problem("host got a sample with no adc result outstanding");
      else
      begin
        exp_value = exp_q.pop_front();
        if (got.value !== exp_value)
          report_mismatch("sample value", exp_value, got.value);
      end
      if (got.seq !== exp_seq)
        report_mismatch("sample seq", exp_seq, got.seq);
      exp_seq = exp_seq + 8'd1;

      repeat (ack_gap) @(posedge clk);
      @(posedge clk);
      #2 rd_ack = 1'b1;
      @(posedge clk);
      #2 rd_ack = 1'b0;
      // counted once the dut has registered it
      ack_count++;
    end
  endtask

  task automatic drive_arm(input logic level);
    @(posedge clk);
    #2 arm_trigger = level;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    int park_window;
    int trig_at_park;

    reset       = 1'b1;
    arm_trigger = 1'b0;
    rd_ack      = 1'b0;
    void'($urandom(85));

    // 1. outputs idle in and right after reset
    start_test("reset");
    repeat (RESET_CYCLES - 1)
    begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    #2 reset = 1'b0;
    // first cycle out of reset, the led has not blinked yet
    @(posedge clk);
    @(negedge clk);
    check_idle_outputs();
    finish_test();

    // 2. free run, values and seq in order
    start_test("free_run");
    repeat (30) receive_sample($urandom % 8);
    finish_test();

    // 3. host stops acking, sequencer must stall on credits
    start_test("backpressure");
    repeat (HOLD_WINDOW) @(negedge clk);
    if (max_outstanding > DEPTH + 1)
      report_mismatch("max unacked triggers", DEPTH + 1, max_outstanding);
    if (trig_count - ack_count != DEPTH + 1)
      report_mismatch("unacked triggers at stall", DEPTH + 1, trig_count - ack_count);
    if (rd_valid !== 1'b1)
      report_mismatch("rd_valid at stall", 1'b1, rd_valid);
    repeat (DEPTH + 6) receive_sample($urandom % 4);
    finish_test();

    // 4. trigger spacing and led blink over the free run so far
    start_test("spacing_led");
    repeat (10) receive_sample($urandom % 8);
    if (min_gap < PRE + 2)
      report_mismatch("min trigger gap", PRE + 2, min_gap);
    if (led_checked == 0)
      report_problem("no trigger was seen for the led check");
    if (led_bad != 0)
      report_mismatch("triggers without one led toggle", 0, led_bad);
    finish_test();

    // 5. park on falling arm, restart on rising arm
    start_test("park_restart");
    led_check_en = 1'b0;
    drive_arm(1'b1);
    repeat (4) receive_sample($urandom % 8);
    drive_arm(1'b0);
    // sync delay plus a trigger issued in the same cycle as the edge
    repeat (8) @(negedge clk);
    trig_at_park = trig_count;
    park_window  = 200 + ($urandom % 200);
    repeat (park_window) @(negedge clk);
    while (exp_q.size() > 0)
      receive_sample($urandom % 8);
    if (trig_count != trig_at_park)
      report_mismatch("triggers while parked", trig_at_park, trig_count);
    drive_arm(1'b1);
    // seq check inside carries on from before the park
    repeat (4) receive_sample($urandom % 8);
    if (trig_count <= trig_at_park)
      report_problem("no trigger after the rising arm edge");
    finish_test();

    // 6. one interrupt per delivered sample
    start_test("interrupt");
    drive_arm(1'b0);
    repeat (100) @(negedge clk);
    while (exp_q.size() > 0)
      receive_sample($urandom % 8);
    repeat (10) @(negedge clk);
    if (rd_valid !== 1'b0)
      report_mismatch("rd_valid after drain", 1'b0, rd_valid);
    if (irq_count != ack_count)
      report_mismatch("interrupt count", ack_count, irq_count);
    if (irq_stray != 0)
      report_mismatch("interrupts without rd_valid", 0, irq_stray);
    if (trig_count != ack_count)
      report_mismatch("triggers vs acks", ack_count, trig_count);
    finish_test();

    $display("summary: %0d tests passed, %0d tests failed, %0d checks failed",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: run still going after %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+rtl
rtl/acq_pkg.sv
rtl/acq_sequencer.sv
rtl/adc_capture.sv
rtl/sample_fifo.sv
rtl/sample_readout.sv
rtl/acq_top.sv
bench/adc_model.sv
bench/tb_acq_top.sv

//--- rtl/acq_defines.svh
// acquisition build parameters

`ifndef ACQ_DEFINES_SVH
`define ACQ_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// sequencer timing

// precharge pause in clk cycles
// kept short for simulation, a hardware build sets the real pause
`define ACQ_PRECHARGE_CYCLES 20

//////////////////////////////////////////////////////////////////////
// sample path

// slots in the sample buffer, power of two
// also the number of credits the sequencer starts with
`define ACQ_FIFO_DEPTH 4

// adc conversion result width
`define ACQ_SAMPLE_WIDTH 24

`endif

//--- rtl/acq_pkg.sv
// acquisition shared types

`include "acq_defines.svh"

package acq_pkg;

  //////////////////////////////////////////////////////////////////////
  // sequencer states

  // non-az cycle is load, pause, trigger, wait for result
  typedef enum logic [2:0] {
    ST_START          = 3'd0,  // single pass after reset
    ST_PRECHARGE_LOAD = 3'd1,  // load pause count, blink led
    ST_PRECHARGE_WAIT = 3'd2,  // count down the pause
    ST_TRIG           = 3'd3,  // wait for credit and idle adc
    ST_WAIT_ADC       = 3'd4,  // conversion outstanding
    ST_PARK           = 3'd5   // halted by falling arm edge
  } acq_state_e;

  //////////////////////////////////////////////////////////////////////
  // sample record

  // one adc result plus its running number, 32 bits total
  typedef struct packed {
    logic [7:0]                   seq;    // wraps at 256
    logic [`ACQ_SAMPLE_WIDTH-1:0] value;  // raw adc code
  } sample_t;

endpackage

//--- rtl/acq_sequencer.sv
// non-az acquisition sequencer

`timescale 1ns/1ps

`include "acq_defines.svh"

module acq_sequencer
  import acq_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic arm_trigger,
  input  logic busy,
  input  logic credit_return,
  output logic adc_measure_trig,
  output logic led0
);

  localparam int CNT_W  = $clog2(`ACQ_PRECHARGE_CYCLES + 1);
  localparam int CRED_W = $clog2(`ACQ_FIFO_DEPTH + 1);

  acq_state_e        state;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] credits;

  // arm line from the host is asynchronous
  logic arm_meta;
  logic arm_sync;
  logic arm_prev;
  logic arm_rise;
  logic arm_fall;

  // busy history, to see the conversion finish
  logic busy_prev;
  logic spend;

  assign arm_rise = arm_sync & ~arm_prev;
  assign arm_fall = ~arm_sync & arm_prev;

  // a trigger is only issued with a credit in hand and the adc idle
  assign spend = (state == ST_TRIG) && (credits != '0) && !busy;

  //////////////////////////////////////////////////////////////////////
  // arm synchronizer and edge history

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      arm_meta  <= 1'b0;
      arm_sync  <= 1'b0;
      arm_prev  <= 1'b0;
      busy_prev <= 1'b0;
    end
    else
    begin
      arm_meta  <= arm_trigger;
      arm_sync  <= arm_meta;
      arm_prev  <= arm_sync;
      busy_prev <= busy;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // credit counter

  // spent on each trigger, returned on each buffer pop
  always_ff @(posedge clk)
  begin
    if (reset)
      credits <= CRED_W'(`ACQ_FIFO_DEPTH);
    else
    begin
      case ({spend, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // both or neither
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // state machine

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state            <= ST_START;
      count            <= '0;
      adc_measure_trig <= 1'b0;
      led0             <= 1'b0;
    end
    else
    begin
      // trigger is a single cycle pulse
      adc_measure_trig <= 1'b0;

      case (state)
        ST_START:
          state <= ST_PRECHARGE_LOAD;

        // pause keeps timing the same as the az mode
        ST_PRECHARGE_LOAD:
        begin
          count <= CNT_W'(`ACQ_PRECHARGE_CYCLES - 1);
          led0  <= ~led0;
          state <= ST_PRECHARGE_WAIT;
        end

        ST_PRECHARGE_WAIT:
        begin
          if (count == '0)
            state <= ST_TRIG;
          else
            count <= count - 1'b1;
        end

        // stall here under back-pressure
        ST_TRIG:
        begin
          if (spend)
          begin
            adc_measure_trig <= 1'b1;
            state            <= ST_WAIT_ADC;
          end
        end

        // busy rises the cycle after the trigger, done when it drops
        ST_WAIT_ADC:
        begin
          if (busy_prev && !busy)
            state <= ST_PRECHARGE_LOAD;
        end

        ST_PARK:
          state <= ST_PARK;

        default:
          state <= ST_START;
      endcase

      // host arm edges win over the case logic
      if (arm_rise)
        state <= ST_PRECHARGE_LOAD;
      else if (arm_fall)
        state <= ST_PARK;
    end
  end

endmodule

//--- rtl/acq_top.sv
// acquisition top level

`timescale 1ns/1ps

`include "acq_defines.svh"

module acq_top
  import acq_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,

  // host side
  input  logic                         arm_trigger,
  output logic                         rd_valid,
  output sample_t                      rd_sample,
  output logic                         spi_irq_n,
  input  logic                         rd_ack,

  // adc side
  output logic                         adc_measure_trig,
  input  logic                         adc_measure_valid,
  input  logic [`ACQ_SAMPLE_WIDTH-1:0] adc_result,

  // status
  output logic                         led0,
  output logic [1:0]                   monitor
);

  logic    busy;
  logic    credit_return;
  logic    push;
  sample_t push_sample;
  logic    not_empty;
  sample_t head;
  logic    pop;

  //////////////////////////////////////////////////////////////////////
  // producer side

  acq_sequencer u_sequencer (
    .clk              (clk),
    .reset            (reset),
    .arm_trigger      (arm_trigger),
    .busy             (busy),
    .credit_return    (credit_return),
    .adc_measure_trig (adc_measure_trig),
    .led0             (led0)
  );

  adc_capture u_capture (
    .clk               (clk),
    .reset             (reset),
    .adc_measure_trig  (adc_measure_trig),
    .adc_measure_valid (adc_measure_valid),
    .adc_result        (adc_result),
    .busy              (busy),
    .push              (push),
    .push_sample       (push_sample)
  );

  //////////////////////////////////////////////////////////////////////
  // consumer side

  sample_fifo u_fifo (
    .clk           (clk),
    .reset         (reset),
    .push          (push),
    .push_sample   (push_sample),
    .pop           (pop),
    .not_empty     (not_empty),
    .head          (head),
    .credit_return (credit_return)
  );

  sample_readout u_readout (
    .clk       (clk),
    .reset     (reset),
    .not_empty (not_empty),
    .head      (head),
    .rd_ack    (rd_ack),
    .pop       (pop),
    .rd_valid  (rd_valid),
    .rd_sample (rd_sample),
    .spi_irq_n (spi_irq_n)
  );

  // scope pins, bit 0 trigger and bit 1 capture push
  assign monitor = {push, adc_measure_trig};

endmodule

//--- rtl/adc_capture.sv
// adc result capture

`timescale 1ns/1ps

`include "acq_defines.svh"

module adc_capture
  import acq_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         adc_measure_trig,
  input  logic                         adc_measure_valid,
  input  logic [`ACQ_SAMPLE_WIDTH-1:0] adc_result,
  output logic                         busy,
  output logic                         push,
  output sample_t                      push_sample
);

  // valid comes from the adc clock domain
  logic       valid_meta;
  logic       valid_sync;
  logic       valid_prev;
  logic       valid_rise;
  logic [7:0] seq_count;

  assign valid_rise = valid_sync & ~valid_prev;

  //////////////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_meta <= 1'b0;
      valid_sync <= 1'b0;
      valid_prev <= 1'b0;
      busy       <= 1'b0;
      push       <= 1'b0;
      seq_count  <= '0;
    end
    else
    begin
      valid_meta <= adc_measure_valid;
      valid_sync <= valid_meta;
      valid_prev <= valid_sync;

      // set on trigger, cleared by the matching valid edge
      if (adc_measure_trig)
        busy <= 1'b1;
      else if (valid_rise)
        busy <= 1'b0;

      // an edge with nothing outstanding is stale, drop it
      push <= valid_rise & busy;
      if (valid_rise && busy)
        seq_count <= seq_count + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload

  // result is stable by the time the synchronized edge shows up
  always_ff @(posedge clk)
  begin
    if (valid_rise && busy)
    begin
      push_sample.seq   <= seq_count;
      push_sample.value <= adc_result;
    end
  end

endmodule

//--- rtl/sample_fifo.sv
// circular sample buffer

`timescale 1ns/1ps

`include "acq_defines.svh"

module sample_fifo
  import acq_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    push,
  input  sample_t push_sample,
  input  logic    pop,
  output logic    not_empty,
  output sample_t head,
  output logic    credit_return
);

  localparam int PTR_W = $clog2(`ACQ_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`ACQ_FIFO_DEPTH + 1);

  sample_t          mem [`ACQ_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  // never full by the credit rule, so push is taken as is
  assign do_pop    = pop & not_empty;
  assign not_empty = (count != '0);

  // head shows the oldest entry, a push appears here next cycle
  assign head = mem[rd_ptr];

  //////////////////////////////////////////////////////////////////////
  // storage

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_sample;
  end

  //////////////////////////////////////////////////////////////////////
  // pointers and occupancy

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end
    else
    begin
      // pointers wrap naturally, depth is a power of two
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;

      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // one slot freed, one credit back to the sequencer
      credit_return <= do_pop;
    end
  end

endmodule

//--- rtl/sample_readout.sv
// host readout stage

`timescale 1ns/1ps

module sample_readout
  import acq_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    not_empty,
  input  sample_t head,
  input  logic    rd_ack,
  output logic    pop,
  output logic    rd_valid,
  output sample_t rd_sample,
  output logic    spi_irq_n
);

  // pull from the buffer whenever the holding register is free
  assign pop = not_empty & ~rd_valid;

  //////////////////////////////////////////////////////////////////////
  // holding register control

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_valid  <= 1'b0;
      spi_irq_n <= 1'b1;
    end
    else
    begin
      if (pop)
        rd_valid <= 1'b1;
      else if (rd_ack && rd_valid)
        rd_valid <= 1'b0;  // free again next cycle

      // low only in the first cycle a sample is held
      spi_irq_n <= ~pop;
    end
  end

  // sample payload
  always_ff @(posedge clk)
  begin
    if (pop)
      rd_sample <= head;
  end

endmodule
